//--- tb.f
design/rv_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_pipe_ctrl.sv
design/rv_core.sv
testbench/tb_rv_core.sv

//--- Makefile
# Verilator build and run of the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_rv_core.sv
// **************************************************
// Testbench for the three-stage RV32I core
// Hand-assembled programs run from an instruction
// memory model; an ISA model predicts every store and
// each store beat is checked against that prediction
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_CYCLES = 24;      // Quiet window after the last store
    localparam int IMEM_AW      = 8;
    localparam int IMEM_WORDS   = 1 << IMEM_AW;
    localparam int MODEL_STEPS  = 4096;
    localparam logic [31:0] SEED     = 32'hb42c_b92e;
    localparam logic [31:0] FILL_KEY = 32'h6c3e_91d5;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_addr;
    logic [31:0] instr_data;
    logic        instr_ready;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_we;
    logic        core_error;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] saved_prog [IMEM_WORDS];
    int          wr_ptr;
    int          saved_len;
    logic [11:0] store_off;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    string       test_name;
    bit          stall_en;
    int          cycle_count;
    int          cycle_limit;
    int          error_count;
    int          tests_run;
    int          tests_failed;

    rv_core u_rv_core (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_addr_o  (instr_addr),
        .instr_data_i  (instr_data),
        .instr_ready_i (instr_ready),
        .mem_addr_o    (mem_addr),
        .mem_wdata_o   (mem_wdata),
        .mem_we_o      (mem_we),
        .error_o       (core_error)
    );

    always #(CLK_HALF) clk = ~clk;

    // Unused words hold an address-keyed pattern
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - rv_pkg::RESET_ADDR) >> 2;
        if (idx < IMEM_WORDS) begin
            return imem[idx[IMEM_AW-1:0]];
        end
        return addr ^ FILL_KEY;
    endfunction

    // Instruction memory answers the PC held since the last rising edge
    always @(negedge clk) begin
        instr_ready <= stall_en ? ($urandom_range(2) != 0) : 1'b1;
        instr_data  <= fetch_word(instr_addr);
    end

    always @(negedge clk) begin
        if (rst_n && mem_we) begin
            assert (exp_addr.size() != 0) else begin
                $display("Test %s stored to %h where no store was expected", test_name, mem_addr);
                error_count++;
            end
            if (exp_addr.size() != 0) begin
                assert (mem_addr == exp_addr[0]) else begin
                    $display("ERR %s store address expected %h actual %h",
                             test_name, exp_addr[0], mem_addr);
                    error_count++;
                end
                assert (mem_wdata == exp_data[0]) else begin
                    $display("ERR %s store data expected %h actual %h",
                             test_name, exp_data[0], mem_wdata);
                    error_count++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Run stopped after %0d cycles, test %s did not finish", cycle_count,
                     test_name);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_pkg::OP_IMM};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    // ISA semantics where alt selects SUB/SRA
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Executes the loaded program until a self-loop or a bad opcode
    task automatic model_stores(output bit hit_invalid);
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        bit          done;
        bit          wr;
        int          steps;
        regs        = '{default: '0};
        hit_invalid = 1'b0;
        done        = 1'b0;
        steps       = 0;
        pc          = rv_pkg::RESET_ADDR;
        exp_addr.delete();
        exp_data.delete();
        while (!done && steps < MODEL_STEPS) begin
            w       = fetch_word(pc);
            a       = regs[w[19:15]];
            b       = regs[w[24:20]];
            imm_i   = {{20{w[31]}}, w[31:20]};
            imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            imm_j   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            next_pc = pc + 32'd4;
            res     = '0;
            wr      = 1'b0;
            case (w[6:0])
                rv_pkg::OP_REG: begin
                    res = ref_alu(w[14:12], w[30], a, b);
                    wr  = 1'b1;
                end
                rv_pkg::OP_IMM: begin
                    res = ref_alu(w[14:12], (w[14:12] == 3'b101) && w[30], a, imm_i);
                    wr  = 1'b1;
                end
                rv_pkg::OP_LUI: begin
                    res = {w[31:12], 12'b0};
                    wr  = 1'b1;
                end
                rv_pkg::OP_STORE: begin
                    exp_addr.push_back(a + imm_s);
                    exp_data.push_back(b);
                end
                rv_pkg::OP_BRANCH: begin
                    if (ref_branch(w[14:12], a, b)) begin
                        next_pc = pc + imm_b;
                    end
                end
                rv_pkg::OP_JAL: begin
                    done    = (imm_j == '0); // Self-loop ends the program
                    res     = pc + 32'd4;
                    wr      = !done;
                    next_pc = pc + imm_j;
                end
                default: begin
                    done        = 1'b1;
                    hit_invalid = 1'b1;
                end
            endcase
            if (wr && w[11:7] != 5'd0) begin
                regs[w[11:7]] = res;
            end
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic emit(input logic [31:0] w);
        imem[wr_ptr[IMEM_AW-1:0]] = w;
        wr_ptr++;
    endtask

    // Each store gets its own slot above the x5 base
    task automatic emit_store(input logic [4:0] rs);
        emit(enc_s(store_off, rs, 5'd5));
        store_off = store_off + 12'd4;
    endtask

    task automatic load_random(input logic [4:0] rd);
        emit({20'($urandom), rd, rv_pkg::OP_LUI});
        emit(enc_i(12'($urandom), rd, 3'b000, rd));
    endtask

    task automatic clear_prog();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i[IMEM_AW-1:0]] = (rv_pkg::RESET_ADDR + 32'(i * 4)) ^ FILL_KEY;
        end
        wr_ptr    = 0;
        store_off = '0;
        emit({20'h10000, 5'd5, rv_pkg::OP_LUI}); // x5 = 0x1000_0000
    endtask

    task automatic build_alu();
        logic [2:0]  f3;
        logic [11:0] imm;
        clear_prog();
        for (int round = 0; round < 3; round++) begin
            load_random(5'd1);
            load_random(5'd2);
            for (int k = 0; k < 10; k++) begin
                f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101);
                emit(enc_r((k >= 8) ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
                emit_store(5'd3);
            end
            for (int k = 0; k < 9; k++) begin
                f3  = (k < 8) ? 3'(k) : 3'b101;
                imm = 12'($urandom);
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {((k == 8) ? 7'h20 : 7'h00), imm[4:0]}; // Shamt only
                end
                emit(enc_i(imm, 5'd1, f3, 5'd4));
                emit_store(5'd4);
            end
        end
        emit(enc_j(21'd0, 5'd0));
    endtask

    task automatic build_chain();
        logic [4:0] prev;
        logic [4:0] dest;
        clear_prog();
        load_random(5'd1);
        emit(enc_i(12'($urandom), 5'd0, 3'b000, 5'd6));
        prev = 5'd6;
        for (int k = 0; k < 16; k++) begin
            dest = 5'(7 + (k % 4));
            case (k % 4)
                0:       emit(enc_r(7'h00, 5'd1, prev, 3'b000, dest));
                1:       emit(enc_i(12'($urandom), prev, 3'b100, dest));
                2:       emit(enc_r(7'h20, prev, 5'd1, 3'b000, dest)); // Via rs2
                default: emit(enc_r(7'h00, prev, 5'd1, 3'b001, dest));
            endcase
            if (k % 2 == 1) begin
                emit_store(dest);
            end
            prev = dest;
        end
        emit(enc_j(21'd0, 5'd0));
    endtask

    // Operand pairs (x1,x2) (x2,x1) (x3,x3) hit both outcomes of every condition
    task automatic build_branch();
        logic [2:0] f3;
        logic [4:0] rs1;
        logic [4:0] rs2;
        clear_prog();
        emit(enc_i(12'hffd, 5'd0, 3'b000, 5'd1)); // -3
        emit(enc_i(12'd7, 5'd0, 3'b000, 5'd2));
        emit(enc_i(12'd5, 5'd0, 3'b000, 5'd3));
        emit(enc_i(12'd0, 5'd0, 3'b000, 5'd10));
        for (int c = 0; c < 6; c++) begin
            f3 = 3'((c < 2) ? c : c + 2);
            for (int p = 0; p < 3; p++) begin
                rs1 = (p == 0) ? 5'd1 : ((p == 1) ? 5'd2 : 5'd3);
                rs2 = (p == 0) ? 5'd2 : ((p == 1) ? 5'd1 : 5'd3);
                emit(enc_b(13'd16, rs2, rs1, f3));
                emit_store(5'd10); // Two flushed and one skipped if taken
                emit_store(5'd10);
                emit_store(5'd10);
                emit(enc_i(12'd1, 5'd10, 3'b000, 5'd10));
                emit_store(5'd10);
            end
        end
        emit(enc_j(21'd0, 5'd0));
    endtask

    task automatic build_jal();
        clear_prog();
        emit(enc_i(12'h055, 5'd0, 3'b000, 5'd10));
        emit(enc_j(21'd12, 5'd12));
        emit_store(5'd10);
        emit_store(5'd10);
        emit_store(5'd12); // Link value
        emit(enc_j(21'd16, 5'd13));
        emit_store(5'd10);
        emit_store(5'd10);
        emit_store(5'd10);
        emit_store(5'd13);
        emit(enc_j(21'd0, 5'd0));
    endtask

    task automatic build_invalid();
        clear_prog();
        emit(enc_i(12'h077, 5'd0, 3'b000, 5'd10));
        emit_store(5'd10);
        emit(32'h0000_007f); // Opcode outside the core's set
        emit_store(5'd10);
        emit(enc_i(12'h001, 5'd10, 3'b000, 5'd10));
        emit_store(5'd10);
        emit(enc_j(21'd0, 5'd0));
    endtask

    task automatic hold_reset();
        @(negedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
    endtask

    task automatic run_test(input string name, input bit stalls);
        int errs_before;
        int n_stores;
        bit exp_error;
        test_name   = name;
        errs_before = error_count;
        stall_en    = stalls;
        model_stores(exp_error);
        n_stores    = exp_addr.size();
        cycle_limit += (wr_ptr + RESET_CYCLES + DRAIN_CYCLES) * 4;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n <= 1'b1;
        do begin
            @(posedge clk);
            #(CLK_HALF / 2);
        end while (exp_addr.size() != 0 || (exp_error && !core_error));
        repeat (DRAIN_CYCLES) @(negedge clk);
        assert (core_error == exp_error) else begin
            $display("ERR %s error_o expected %0b actual %0b", name, exp_error, core_error);
            error_count++;
        end
        tests_run++;
        if (error_count != errs_before) begin
            tests_failed++;
        end
        $display("test %s: %s, %0d stores expected, %0d errors", name,
                 (error_count == errs_before) ? "ok" : "FAILED", n_stores,
                 error_count - errs_before);
    endtask

    initial begin
        void'($urandom(SEED));
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr_ready  = 1'b0;
        instr_data   = rv_pkg::NOP_INSTR;
        stall_en     = 1'b0;
        cycle_count  = 0;
        cycle_limit  = 0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;

        build_alu();
        saved_prog = imem;
        saved_len  = wr_ptr;
        run_test("alu", 1'b0);
        hold_reset();
        build_chain();
        run_test("chain", 1'b0);
        hold_reset();
        build_branch();
        run_test("branch", 1'b0);
        hold_reset();
        build_jal();
        run_test("jal", 1'b0);
        hold_reset();
        imem   = saved_prog; // Same ALU program with fetch gaps
        wr_ptr = saved_len;
        run_test("stall", 1'b1);
        hold_reset();
        build_invalid();
        run_test("invalid", 1'b0);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/rv_core.sv
// ************************************************
// Three-stage RV32I core with fetch, decode and execute
// Holds the PC, IF/ID and ID/EX registers and the
// registered store port; writeback at end of execute
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic [rv_pkg::XLEN-1:0]   instr_addr_o,
    input  logic [rv_pkg::XLEN-1:0]   instr_data_i,
    input  logic                      instr_ready_i,
    output logic [rv_pkg::XLEN-1:0]   mem_addr_o,
    output logic [rv_pkg::XLEN-1:0]   mem_wdata_o,
    output logic                      mem_we_o,
    output logic                      error_o
);

    logic [rv_pkg::XLEN-1:0] pc;
    logic [rv_pkg::XLEN-1:0] pc_next;
    rv_pkg::instr_u          if_id_instr;
    logic [rv_pkg::XLEN-1:0] if_id_pc;
    rv_pkg::id_ex_t          id_ex;
    rv_pkg::id_ex_t          id_ex_d;

    rv_pkg::ctrl_t           dec_ctrl;
    logic [rv_pkg::XLEN-1:0] dec_imm;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;

    logic [rv_pkg::XLEN-1:0] alu_a;
    logic [rv_pkg::XLEN-1:0] alu_b;
    logic [rv_pkg::XLEN-1:0] alu_result;
    logic [rv_pkg::XLEN-1:0] ex_target;
    logic [rv_pkg::XLEN-1:0] wb_data;
    logic                    wb_we;
    logic                    branch_taken;
    logic                    redirect;
    logic                    advance;
    logic                    flush;
    logic                    halted;

    rv_decode u_rv_decode (
        .instr_i (if_id_instr),
        .ctrl_o  (dec_ctrl),
        .imm_o   (dec_imm)
    );

    rv_regfile u_rv_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (if_id_instr.ri.rs1),
        .rs2_addr_i (if_id_instr.ri.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .rd_we_i    (wb_we),
        .rd_addr_i  (id_ex.rd),
        .rd_data_i  (wb_data)
    );

    rv_alu u_rv_alu (
        .op_i           (id_ex.ctrl.alu_op),
        .a_i            (alu_a),
        .b_i            (alu_b),
        .cmp_a_i        (id_ex.rs1_val),
        .cmp_b_i        (id_ex.rs2_val),
        .funct3_i       (id_ex.funct3),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken)
    );

    rv_pipe_ctrl u_rv_pipe_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_ready_i (instr_ready_i),
        .redirect_i    (redirect),
        .invalid_i     (id_ex.ctrl.invalid),
        .advance_o     (advance),
        .flush_o       (flush),
        .halted_o      (halted)
    );

    // Decode stage bundle
    always_comb begin
        id_ex_d         = '0;
        id_ex_d.ctrl    = dec_ctrl;
        id_ex_d.pc      = if_id_pc;
        id_ex_d.imm     = dec_imm;
        id_ex_d.rd      = if_id_instr.ri.rd;
        id_ex_d.rs1_val = rs1_data;
        id_ex_d.rs2_val = rs2_data;
        id_ex_d.funct3  = if_id_instr.ri.funct3;
    end

    // Execute stage
    assign alu_a     = id_ex.ctrl.is_lui ? '0 : id_ex.rs1_val;
    assign alu_b     = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.rs2_val;
    assign ex_target = id_ex.pc + id_ex.imm;
    assign redirect  = id_ex.ctrl.is_jal || (id_ex.ctrl.is_branch && branch_taken);
    assign wb_data   = id_ex.ctrl.is_jal ? id_ex.pc + 32'd4 : alu_result; // Link value
    assign wb_we     = advance && id_ex.ctrl.reg_we;

    assign pc_next      = redirect ? ex_target : pc + 32'd4;
    assign instr_addr_o = pc;
    assign error_o      = halted; // Sticky until reset

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= rv_pkg::RESET_ADDR;
            if_id_instr <= rv_pkg::NOP_INSTR;
            if_id_pc    <= rv_pkg::RESET_ADDR;
            id_ex       <= '0; // Bubble that acts as the NOP word
        end else if (advance) begin
            pc       <= pc_next;
            if_id_pc <= pc;
            if (flush) begin
                if_id_instr <= rv_pkg::NOP_INSTR;
                id_ex       <= '0;
            end else begin
                if_id_instr <= instr_data_i;
                id_ex       <= id_ex_d;
            end
        end
    end

    // Store strobe lasts one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_we_o <= 1'b0;
        end else begin
            mem_we_o <= advance && id_ex.ctrl.is_store;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && id_ex.ctrl.is_store) begin
            mem_addr_o  <= alu_result;
            mem_wdata_o <= id_ex.rs2_val;
        end
    end

endmodule

`default_nettype wire

//--- design/rv_pipe_ctrl.sv
// ************************************************
// Pipeline controller FSM with states RUN and HALT
// Advances on a ready fetch, flushes on a redirect,
// and halts for good on an invalid instruction
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic instr_ready_i,
    input  logic redirect_i,
    input  logic invalid_i,
    output logic advance_o,
    output logic flush_o,
    output logic halted_o
);

    logic state;
    logic state_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rv_pkg::ST_RUN;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        advance_o  = 1'b0;
        flush_o    = 1'b0;
        case (state)
            rv_pkg::ST_RUN: begin
                advance_o = instr_ready_i;
                flush_o   = instr_ready_i && redirect_i;
                // Only an instruction that actually retires can halt
                if (instr_ready_i && invalid_i) begin
                    state_next = rv_pkg::ST_HALT;
                end
            end
            default: begin
                state_next = rv_pkg::ST_HALT; // Left only through reset
            end
        endcase
    end

    assign halted_o = (state == rv_pkg::ST_HALT);

endmodule

`default_nettype wire

//--- design/rv_alu.sv
// ************************************************
// Execute-stage ALU and branch comparator
// Ten integer operations on a/b, and the six branch
// conditions on the compare operands
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  rv_pkg::alu_op_t               op_i,
    input  logic [rv_pkg::XLEN-1:0]       a_i,
    input  logic [rv_pkg::XLEN-1:0]       b_i,
    input  logic [rv_pkg::XLEN-1:0]       cmp_a_i,
    input  logic [rv_pkg::XLEN-1:0]       cmp_b_i,
    input  logic [2:0]                    funct3_i,
    output logic [rv_pkg::XLEN-1:0]       result_o,
    output logic                          branch_taken_o
);

    logic cmp_eq;
    logic cmp_lt;
    logic cmp_ltu;

    always_comb begin
        case (op_i)
            rv_pkg::ALU_ADD:  result_o = a_i + b_i;
            rv_pkg::ALU_SUB:  result_o = a_i - b_i;
            rv_pkg::ALU_SLL:  result_o = a_i << b_i[4:0];
            rv_pkg::ALU_SLT:  result_o = {{(rv_pkg::XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            rv_pkg::ALU_SLTU: result_o = {{(rv_pkg::XLEN-1){1'b0}}, a_i < b_i};
            rv_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            rv_pkg::ALU_SRL:  result_o = a_i >> b_i[4:0];
            rv_pkg::ALU_SRA:  result_o = $signed(a_i) >>> b_i[4:0];
            rv_pkg::ALU_OR:   result_o = a_i | b_i;
            rv_pkg::ALU_AND:  result_o = a_i & b_i;
            default:          result_o = a_i + b_i;
        endcase
    end

    assign cmp_eq  = (cmp_a_i == cmp_b_i);
    assign cmp_lt  = ($signed(cmp_a_i) < $signed(cmp_b_i));
    assign cmp_ltu = (cmp_a_i < cmp_b_i);

    always_comb begin
        case (funct3_i)
            3'b000:  branch_taken_o = cmp_eq;   // BEQ
            3'b001:  branch_taken_o = !cmp_eq;  // BNE
            3'b100:  branch_taken_o = cmp_lt;   // BLT
            3'b101:  branch_taken_o = !cmp_lt;  // BGE
            3'b110:  branch_taken_o = cmp_ltu;  // BLTU
            3'b111:  branch_taken_o = !cmp_ltu; // BGEU
            default: branch_taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv_regfile.sv
// ************************************************
// Integer register file, two read ports, one write
// x0 reads as zero; a same-cycle write is bypassed
// to the read ports
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::REG_AW-1:0]     rs1_addr_i,
    input  logic [rv_pkg::REG_AW-1:0]     rs2_addr_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
    input  logic                          rd_we_i,
    input  logic [rv_pkg::REG_AW-1:0]     rd_addr_i,
    input  logic [rv_pkg::XLEN-1:0]       rd_data_i
);

    logic [rv_pkg::XLEN-1:0] regs [1:(1 << rv_pkg::REG_AW)-1];

    function automatic logic [rv_pkg::XLEN-1:0] read_port(
        input logic [rv_pkg::REG_AW-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (rd_we_i && (addr == rd_addr_i)) begin
            return rd_data_i; // Write-through
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < (1 << rv_pkg::REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we_i && (rd_addr_i != '0)) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    always_comb rs1_data_o = read_port(rs1_addr_i);
    always_comb rs2_data_o = read_port(rs2_addr_i);

endmodule

`default_nettype wire

//--- design/rv_decode.sv
// ************************************************
// Instruction decoder for the decode stage
// Reads the IF/ID word through both union views and
// returns the control struct and the immediate
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  rv_pkg::instr_u               instr_i,
    output rv_pkg::ctrl_t                ctrl_o,
    output logic [rv_pkg::XLEN-1:0]      imm_o
);

    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_s;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_j;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic                    sra_bit;

    // I and U from the R/I view
    assign imm_i = {{20{instr_i.ri.funct7[6]}}, instr_i.ri.funct7, instr_i.ri.rs2};
    assign imm_u = {instr_i.ri.funct7, instr_i.ri.rs2, instr_i.ri.rs1,
                    instr_i.ri.funct3, 12'b0};
    assign imm_j = {{12{instr_i.ri.funct7[6]}}, instr_i.ri.rs1, instr_i.ri.funct3,
                    instr_i.ri.rs2[0], instr_i.ri.funct7[5:0], instr_i.ri.rs2[4:1], 1'b0};

    // S and B from the S/B view
    assign imm_s = {{20{instr_i.sb.imm_hi[6]}}, instr_i.sb.imm_hi, instr_i.sb.imm_lo};
    assign imm_b = {{20{instr_i.sb.imm_hi[6]}}, instr_i.sb.imm_lo[0],
                    instr_i.sb.imm_hi[5:0], instr_i.sb.imm_lo[4:1], 1'b0};

    // Immediate shifts only carry an op bit for SRLI/SRAI
    assign sra_bit = (instr_i.ri.funct3 == 3'b101) ? instr_i.ri.funct7[5] : 1'b0;

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = rv_pkg::ALU_ADD; // Address and LUI paths add
        imm_o         = '0;
        case (instr_i.ri.opcode)
            rv_pkg::OP_REG: begin
                ctrl_o.alu_op = rv_pkg::alu_op_t'({instr_i.ri.funct7[5], instr_i.ri.funct3});
                ctrl_o.reg_we = 1'b1;
            end
            rv_pkg::OP_IMM: begin
                ctrl_o.alu_op  = rv_pkg::alu_op_t'({sra_bit, instr_i.ri.funct3});
                ctrl_o.reg_we  = 1'b1;
                ctrl_o.use_imm = 1'b1;
                imm_o          = imm_i;
            end
            rv_pkg::OP_STORE: begin
                ctrl_o.is_store = 1'b1;
                ctrl_o.use_imm  = 1'b1;
                imm_o           = imm_s;
            end
            rv_pkg::OP_BRANCH: begin
                ctrl_o.is_branch = 1'b1;
                imm_o            = imm_b;
            end
            rv_pkg::OP_JAL: begin
                ctrl_o.is_jal = 1'b1;
                ctrl_o.reg_we = 1'b1; // Link register
                imm_o         = imm_j;
            end
            rv_pkg::OP_LUI: begin
                ctrl_o.is_lui  = 1'b1;
                ctrl_o.reg_we  = 1'b1;
                ctrl_o.use_imm = 1'b1;
                imm_o          = imm_u;
            end
            default: ctrl_o.invalid = 1'b1; // No write, no store
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv_pkg.sv
// ************************************************
// Shared definitions for the three-stage RV32I core
// Widths, opcodes, ALU encoding and the stage structs
// Referenced by scoped names from every design file
// ************************************************
`default_nettype none

package rv_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] RESET_ADDR = 32'h8000_0000;
    localparam logic [XLEN-1:0] NOP_INSTR  = 32'h0000_0013; // ADDI x0,x0,0

    // Kept opcode set
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    // Pipeline controller states
    localparam logic ST_RUN  = 1'b0;
    localparam logic ST_HALT = 1'b1;

    // {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_t;

    typedef struct packed {
        logic [6:0]        funct7; // Upper I-immediate bits as well
        logic [REG_AW-1:0] rs2;    // Lower I-immediate bits as well
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } instr_ri_t;

    typedef struct packed {
        logic [6:0]        imm_hi;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        imm_lo;
        logic [6:0]        opcode;
    } instr_sb_t;

    typedef union packed {
        instr_ri_t ri;
        instr_sb_t sb;
    } instr_u;

    typedef struct packed {
        alu_op_t alu_op;
        logic    is_branch;
        logic    is_jal;
        logic    is_store;
        logic    is_lui;   // Operand A forced to zero
        logic    reg_we;
        logic    use_imm;  // Operand B from immediate
        logic    invalid;
    } ctrl_t;

    typedef struct packed {
        ctrl_t             ctrl;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   rs1_val;
        logic [XLEN-1:0]   rs2_val;
        logic [2:0]        funct3;
    } id_ex_t;

endpackage

`default_nettype wire
